/* cpuCore.f */
+incdir+.
cpuPkg.sv
cpuFetch.sv
cpuDecode.sv
cpuExecute.sv
cpuMemWrite.sv
cpuHazard.sv
cpuCore.sv
tbCpu.sv

/* Makefile */
SRCS = cpuPkg.sv cpuFetch.sv cpuDecode.sv cpuExecute.sv cpuMemWrite.sv \
       cpuHazard.sv cpuCore.sv tbCpu.sv tbCpuModel.svh

obj_dir/VtbCpu: cpuCore.f $(SRCS)
	verilator --binary --timing --assert --top-module tbCpu -f cpuCore.f

.PHONY: run clean

run: obj_dir/VtbCpu
	@out="$$(./obj_dir/VtbCpu)"; echo "$$out"; echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

/* tbCpuModel.svh */
//##############################
// instruction encoders, random program
// generator and in-order reference model
//##############################

// program layout: body, its exit jump, a subroutine, the halt slot
localparam int bodyEnd  = 52;
localparam int subStart = 53;
localparam int subEnd   = 62;
localparam int haltPc   = 63;

cpuPkg::word_t progMem [256];
cpuPkg::word_t mReg [32];
cpuPkg::word_t mMem [256];
// expected streams, {index, data} and {address, data}
logic [36:0] expReg [$];
logic [63:0] expMem [$];

function automatic cpuPkg::word_t encR(input cpuPkg::regIdx_t rd, input cpuPkg::regIdx_t rs,
                                       input cpuPkg::regIdx_t rt, input logic [4:0] shamt,
                                       input cpuPkg::aluOp_t alu);
    return {cpuPkg::opRtype, rd, rs, rt, shamt, alu, 2'b00};
endfunction

function automatic cpuPkg::word_t encI(input cpuPkg::opcode_t op, input cpuPkg::regIdx_t rd,
                                       input cpuPkg::regIdx_t rs, input logic [16:0] imm);
    return {op, rd, rs, imm};
endfunction

function automatic cpuPkg::word_t encJ(input cpuPkg::opcode_t op, input logic [26:0] target);
    return {op, target};
endfunction

// half the sources reuse the latest destination to force bypasses
function automatic cpuPkg::regIdx_t pickSrc(input cpuPkg::regIdx_t recent);
    if (randBits(1) == 32'd1)
        return recent;
    else
        return 5'(randBits(5));
endfunction

task automatic buildProgram();
    cpuPkg::regIdx_t recent;
    cpuPkg::regIdx_t rd;
    logic [3:0] kind;
    logic [16:0] off;
    int limit;
    int calls;
    recent = 5'd1;
    calls = 0;
    for (int p = 0; p < 256; p++)
        progMem[p] = encJ(cpuPkg::opJ, 27'(haltPc));
    for (int p = 0; p < haltPc; p++) begin
        if (p == bodyEnd) begin
            progMem[p] = encJ(cpuPkg::opJ, 27'(haltPc));
            continue;
        end
        if (p == subEnd) begin
            // return from the subroutine
            progMem[p] = encI(cpuPkg::opJr, cpuPkg::linkReg, 5'd0, 17'd0);
            continue;
        end
        limit = (p < bodyEnd) ? bodyEnd : subEnd;
        // forward offset that stays inside the current block
        off = 17'(randBits(3) % 32'(limit - p));
        // r31 belongs to jal, r0 writes stay in the mix
        rd = 5'(randBits(5));
        if (rd == cpuPkg::linkReg)
            rd = 5'd0;
        kind = 4'(randBits(4));
        case (kind)
            4'd0, 4'd1, 4'd2, 4'd3, 4'd4:
                progMem[p] = encR(rd, pickSrc(recent), pickSrc(recent), 5'(randBits(5)),
                                  5'(randBits(3) % 32'd6));
            4'd7, 4'd8:
                progMem[p] = encI(cpuPkg::opLw, rd, 5'd0, {9'd0, 8'(randBits(8))});
            4'd9, 4'd10:
                progMem[p] = encI(cpuPkg::opSw, pickSrc(recent), 5'd0, {9'd0, 8'(randBits(8))});
            4'd11:
                progMem[p] = encI(cpuPkg::opBne, pickSrc(recent), pickSrc(recent), off);
            4'd12:
                progMem[p] = encI(cpuPkg::opBlt, pickSrc(recent), pickSrc(recent), off);
            4'd13:
                progMem[p] = encJ(cpuPkg::opJ, 27'(p + 1 + int'(off)));
            4'd14: begin
                // calls only from the body, a few per program
                if (p < bodyEnd && calls < 3) begin
                    progMem[p] = encJ(cpuPkg::opJal, 27'(subStart));
                    calls++;
                end else begin
                    progMem[p] = encI(cpuPkg::opAddi, rd, pickSrc(recent), 17'(randBits(17)));
                end
            end
            4'd15:
                progMem[p] = {5'(32'd9 + randBits(3)), 27'(randBits(27))};
            default:
                progMem[p] = encI(cpuPkg::opAddi, rd, pickSrc(recent), 17'(randBits(17)));
        endcase
        if (kind <= 4'd8 || kind == 4'd14)
            recent = rd;
    end
endtask

task automatic writeReg(input cpuPkg::regIdx_t idx, input cpuPkg::word_t val);
    if (idx != 5'd0) begin
        mReg[idx] = val;
        expReg.push_back({idx, val});
    end
endtask

// executes one instruction at a time until the halt slot
task automatic runModel();
    cpuPkg::word_t pc;
    cpuPkg::word_t ins;
    cpuPkg::word_t imm;
    cpuPkg::word_t addr;
    cpuPkg::word_t d;
    cpuPkg::word_t s;
    cpuPkg::word_t t;
    int steps;
    expReg.delete();
    expMem.delete();
    pc = '0;
    steps = 0;
    while (pc != 32'(haltPc) && steps < 1000) begin
        ins = progMem[pc[7:0]];
        imm = {{15{ins[16]}}, ins[16:0]};
        d = mReg[ins[26:22]];
        s = mReg[ins[21:17]];
        t = mReg[ins[16:12]];
        addr = s + imm;
        pc = pc + 32'd1;
        case (ins[31:27])
            cpuPkg::opRtype: begin
                case (ins[6:2])
                    cpuPkg::aluAdd: writeReg(ins[26:22], s + t);
                    cpuPkg::aluSub: writeReg(ins[26:22], s - t);
                    cpuPkg::aluAnd: writeReg(ins[26:22], s & t);
                    cpuPkg::aluOr:  writeReg(ins[26:22], s | t);
                    cpuPkg::aluSll: writeReg(ins[26:22], s << ins[11:7]);
                    cpuPkg::aluSra: writeReg(ins[26:22], $signed(s) >>> ins[11:7]);
                    default: ;
                endcase
            end
            cpuPkg::opAddi: writeReg(ins[26:22], addr);
            cpuPkg::opLw:   writeReg(ins[26:22], mMem[addr[7:0]]);
            cpuPkg::opSw: begin
                mMem[addr[7:0]] = d;
                expMem.push_back({addr, d});
            end
            cpuPkg::opBne: if (d != s) pc = pc + imm;
            cpuPkg::opBlt: if ($signed(d) < $signed(s)) pc = pc + imm;
            cpuPkg::opJ:   pc = {5'd0, ins[26:0]};
            cpuPkg::opJal: begin
                // link value is already PC+1
                writeReg(cpuPkg::linkReg, pc);
                pc = {5'd0, ins[26:0]};
            end
            cpuPkg::opJr: pc = d;
            default: ;
        endcase
        steps++;
    end
endtask

/* tbCpu.sv */
//##############################
// testbench for the five-stage core
// memories, register file, random programs,
// stream checks and watchdog
//##############################
`timescale 1ns/1ns
module tbCpu;

    localparam int numProgs    = 20;
    localparam int progLen     = 64;
    localparam int resetCycles = 8;
    localparam int drainCycles = 8;
    // six cycles per instruction, plus reset and drain of each program
    localparam int maxCycles = numProgs * (progLen * 6 + resetCycles + drainCycles + 4);

    logic            clock;
    logic            arstN;
    cpuPkg::word_t   imemAddr;
    cpuPkg::word_t   imemQ;
    cpuPkg::word_t   dmemAddr;
    cpuPkg::word_t   dmemData;
    logic            dmemWren;
    cpuPkg::word_t   dmemQ;
    logic            regWriteEn;
    cpuPkg::regIdx_t regWriteIdx;
    cpuPkg::word_t   regWriteData;
    cpuPkg::regIdx_t readIdxA;
    cpuPkg::regIdx_t readIdxB;
    cpuPkg::word_t   readDataA;
    cpuPkg::word_t   readDataB;

    cpuPkg::word_t imem [256];
    cpuPkg::word_t dmem [256];
    cpuPkg::word_t rf [32];
    logic [36:0] gotReg [$];
    logic [63:0] gotMem [$];
    logic [31:0] lfsr;
    int errors;
    int cycles;
    int haltRun;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] val;
        logic fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val = {val[30:0], fb};
        end
        return val;
    endfunction

    `include "tbCpuModel.svh"

    // memories and register file answer combinationally
    assign imemQ     = imem[imemAddr[7:0]];
    assign dmemQ     = dmem[dmemAddr[7:0]];
    assign readDataA = rf[readIdxA];
    assign readDataB = rf[readIdxB];

    // register file write port, taken on the rising edge
    // decode sees the value one cycle earlier only through its own bypass
    always @(posedge clock) begin
        if (regWriteEn)
            rf[regWriteIdx] <= regWriteData;
    end

    cpuCore #(.resetPc('0)) u_dut (
        .clock(clock), .arstN(arstN), .imemAddr(imemAddr), .imemQ(imemQ),
        .dmemAddr(dmemAddr), .dmemData(dmemData), .dmemWren(dmemWren), .dmemQ(dmemQ),
        .regWriteEn(regWriteEn), .regWriteIdx(regWriteIdx), .regWriteData(regWriteData),
        .readIdxA(readIdxA), .readIdxB(readIdxB), .readDataA(readDataA), .readDataB(readDataB)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // same start state for the DUT side and the model
    task automatic loadProgram(input int prog);
        cpuPkg::word_t initVal;
        for (int i = 0; i < 256; i++) begin
            imem[i] = progMem[i];
            dmem[i] = (32'(i) * 32'h9e3779b1) ^ 32'(prog);
            mMem[i] = dmem[i];
        end
        rf[0] <= '0;
        mReg[0] = '0;
        for (int i = 1; i < 32; i++) begin
            initVal = randBits(32);
            rf[i] <= initVal;
            mReg[i] = initVal;
        end
    endtask

    // write enables hold for a whole cycle, so one look per falling edge
    task automatic sampleWrites();
        if (regWriteEn) begin
            if (regWriteIdx == 5'd0) begin
                errors++;
                $display("register write enable raised for r0");
            end
            gotReg.push_back({regWriteIdx, regWriteData});
        end
        if (dmemWren) begin
            gotMem.push_back({dmemAddr, dmemData});
            dmem[dmemAddr[7:0]] = dmemData;
        end
    endtask

    task automatic compareStreams(input int prog);
        if (gotReg.size() != expReg.size()) begin
            errors++;
            $display("Mismatch prog%0d regWriteCount expected %0d actual %0d",
                     prog, expReg.size(), gotReg.size());
        end
        for (int k = 0; k < gotReg.size() && k < expReg.size(); k++) begin
            if (gotReg[k] != expReg[k]) begin
                errors++;
                $display("Mismatch prog%0d regWrite[%0d] expected r%0d=%h actual r%0d=%h",
                         prog, k, expReg[k][36:32], expReg[k][31:0],
                         gotReg[k][36:32], gotReg[k][31:0]);
            end
        end
        if (gotMem.size() != expMem.size()) begin
            errors++;
            $display("Mismatch prog%0d memWriteCount expected %0d actual %0d",
                     prog, expMem.size(), gotMem.size());
        end
        for (int k = 0; k < gotMem.size() && k < expMem.size(); k++) begin
            if (gotMem[k] != expMem[k]) begin
                errors++;
                $display("Mismatch prog%0d memWrite[%0d] expected [%h]=%h actual [%h]=%h",
                         prog, k, expMem[k][63:32], expMem[k][31:0],
                         gotMem[k][63:32], gotMem[k][31:0]);
            end
        end
        if (rf[0] != '0) begin
            errors++;
            $display("Mismatch prog%0d r0 expected %h actual %h", prog, 32'd0, rf[0]);
        end
    endtask

    initial begin
        arstN = 1'b0;
        lfsr = 32'hd5ea4525;
        errors = 0;
        for (int prog = 0; prog < numProgs; prog++) begin
            if (prog != 0)
                @(negedge clock);
            arstN = 1'b0;
            buildProgram();
            loadProgram(prog);
            runModel();
            gotReg.delete();
            gotMem.delete();
            // nothing may write and fetch sits at 0 while in reset
            repeat (resetCycles) begin
                @(negedge clock);
                if (dmemWren || regWriteEn || imemAddr != 32'd0) begin
                    errors++;
                    $display("prog%0d: write enable or fetch address active during reset", prog);
                end
            end
            arstN = 1'b1;
            // done once fetch has circled in the halt loop for a few cycles
            cycles = 0;
            haltRun = 0;
            while (haltRun < 4 && cycles < progLen * 6) begin
                @(negedge clock);
                cycles++;
                sampleWrites();
                if (imemAddr >= 32'(haltPc))
                    haltRun++;
                else
                    haltRun = 0;
            end
            if (haltRun < 4) begin
                errors++;
                $display("prog%0d never settled on its final jump", prog);
            end
            repeat (drainCycles) begin
                @(negedge clock);
                sampleWrites();
            end
            compareStreams(prog);
        end
        $display("errors: %0d", errors);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        #(maxCycles * 10);
        $display("watchdog expired after %0d cycles", maxCycles);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

/* cpuCore.sv */
//##############################
// five-stage core top level
// memories and register file sit outside
//##############################
`timescale 1ns/1ns
module cpuCore #(
    parameter cpuPkg::word_t resetPc = '0
) (
    input  logic            clock,
    input  logic            arstN,
    output cpuPkg::word_t   imemAddr,
    input  cpuPkg::word_t   imemQ,
    output cpuPkg::word_t   dmemAddr,
    output cpuPkg::word_t   dmemData,
    output logic            dmemWren,
    input  cpuPkg::word_t   dmemQ,
    output logic            regWriteEn,
    output cpuPkg::regIdx_t regWriteIdx,
    output cpuPkg::word_t   regWriteData,
    output cpuPkg::regIdx_t readIdxA,
    output cpuPkg::regIdx_t readIdxB,
    input  cpuPkg::word_t   readDataA,
    input  cpuPkg::word_t   readDataB
);

    cpuPkg::fdReg_t     fd;
    cpuPkg::dxReg_t     dx;
    cpuPkg::xmReg_t     xm;
    cpuPkg::mwReg_t     mw;
    cpuPkg::word_t      redirectPc;
    cpuPkg::word_t      memResult;
    cpuPkg::bypassSel_t selA;
    cpuPkg::bypassSel_t selB;
    logic stall;
    logic redirect;
    logic storeBypass;
    logic decNeedsB;

    cpuFetch #(.resetPc(resetPc)) u_fetch (
        .clock(clock), .arstN(arstN), .stall(stall), .redirect(redirect),
        .redirectPc(redirectPc), .instr(imemQ), .imemAddr(imemAddr), .fd(fd)
    );

    // writeback feeds decode through the register file write port signals
    cpuDecode u_decode (
        .clock(clock), .arstN(arstN), .fd(fd), .stall(stall), .redirect(redirect),
        .readIdxA(readIdxA), .readIdxB(readIdxB),
        .readDataA(readDataA), .readDataB(readDataB),
        .wbIdx(regWriteIdx), .wbData(regWriteData), .wbEn(regWriteEn),
        .decNeedsB(decNeedsB), .dx(dx)
    );

    cpuExecute u_execute (
        .clock(clock), .arstN(arstN), .dx(dx), .selA(selA), .selB(selB),
        .memResult(memResult), .wbData(regWriteData),
        .redirect(redirect), .redirectPc(redirectPc), .xm(xm)
    );

    cpuMemWrite u_memWrite (
        .clock(clock), .arstN(arstN), .xm(xm), .storeBypass(storeBypass),
        .wbData(regWriteData), .dmemAddr(dmemAddr), .dmemData(dmemData),
        .dmemWren(dmemWren), .dmemQ(dmemQ), .wbIdx(regWriteIdx), .wbEn(regWriteEn),
        .memResult(memResult), .mw(mw)
    );

    cpuHazard u_hazard (
        .decIdxA(readIdxA), .decIdxB(readIdxB), .decNeedsB(decNeedsB),
        .dx(dx), .xm(xm), .mw(mw),
        .stall(stall), .selA(selA), .selB(selB), .storeBypass(storeBypass)
    );

endmodule

/* cpuHazard.sv */
//##############################
// hazard unit
// bypass selects and load-use stall
//##############################
`timescale 1ns/1ns
module cpuHazard (
    input  cpuPkg::regIdx_t    decIdxA,
    input  cpuPkg::regIdx_t    decIdxB,
    input  logic               decNeedsB,
    input  cpuPkg::dxReg_t     dx,
    input  cpuPkg::xmReg_t     xm,
    input  cpuPkg::mwReg_t     mw,
    output logic               stall,
    output cpuPkg::bypassSel_t selA,
    output cpuPkg::bypassSel_t selB,
    output logic               storeBypass
);

    // r0 is never a real producer
    function automatic logic hit(input logic en, input cpuPkg::regIdx_t dest,
                                 input cpuPkg::regIdx_t src);
        return en && dest != '0 && dest == src;
    endfunction

    // the younger producer in memory wins over writeback
    function automatic cpuPkg::bypassSel_t pickSel(input cpuPkg::regIdx_t src,
                                                   input logic xmEn,
                                                   input cpuPkg::regIdx_t xmDest,
                                                   input logic mwEn,
                                                   input cpuPkg::regIdx_t mwDest);
        if (hit(xmEn, xmDest, src))
            return cpuPkg::selMem;
        else if (hit(mwEn, mwDest, src))
            return cpuPkg::selWb;
        else
            return cpuPkg::selReg;
    endfunction

    assign selA = pickSel(dx.srcA, xm.ctrl.regWrite, xm.dest, mw.regWrite, mw.dest);
    assign selB = pickSel(dx.srcB, xm.ctrl.regWrite, xm.dest, mw.regWrite, mw.dest);

    // sw one behind its producer picks the value up in memory
    assign storeBypass = xm.ctrl.memWrite && hit(mw.regWrite, mw.dest, xm.storeIdx);

    // load data exists only from writeback on, hold decode one cycle
    assign stall = dx.ctrl.memRead &&
                   (hit(dx.ctrl.regWrite, dx.dest, decIdxA) ||
                    (decNeedsB && hit(dx.ctrl.regWrite, dx.dest, decIdxB)));

endmodule

/* cpuMemWrite.sv */
//##############################
// memory and writeback stages
// data memory drive, store bypass,
// memory/writeback register, write port
//##############################
`timescale 1ns/1ns
module cpuMemWrite (
    input  logic            clock,
    input  logic            arstN,
    input  cpuPkg::xmReg_t  xm,
    input  logic            storeBypass,
    output cpuPkg::word_t   wbData,
    output cpuPkg::word_t   dmemAddr,
    output cpuPkg::word_t   dmemData,
    output logic            dmemWren,
    input  cpuPkg::word_t   dmemQ,
    output cpuPkg::regIdx_t wbIdx,
    output logic            wbEn,
    output cpuPkg::word_t   memResult,
    output cpuPkg::mwReg_t  mw
);

    // ALU result is the data address
    assign dmemAddr = xm.result;
    // store of a value the previous instruction is writing back now
    assign dmemData = storeBypass ? wbData : xm.storeData;
    assign dmemWren = xm.ctrl.memWrite;

    // forwarded to execute
    assign memResult = xm.result;

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            mw <= '0;
        end else begin
            mw <= '{
                result:   xm.result,
                loadData: dmemQ,
                dest:     xm.dest,
                regWrite: xm.ctrl.regWrite,
                memRead:  xm.ctrl.memRead
            };
        end
    end

    // register file write port
    assign wbData = mw.memRead ? mw.loadData : mw.result;
    assign wbIdx  = mw.dest;
    assign wbEn   = mw.regWrite;

endmodule

/* cpuExecute.sv */
//##############################
// execute stage
// operand bypass, ALU, branch and jump
// resolution, execute/memory register
//##############################
`timescale 1ns/1ns
module cpuExecute (
    input  logic               clock,
    input  logic               arstN,
    input  cpuPkg::dxReg_t     dx,
    input  cpuPkg::bypassSel_t selA,
    input  cpuPkg::bypassSel_t selB,
    input  cpuPkg::word_t      memResult,
    input  cpuPkg::word_t      wbData,
    output logic               redirect,
    output cpuPkg::word_t      redirectPc,
    output cpuPkg::xmReg_t     xm
);

    cpuPkg::word_t opA;
    cpuPkg::word_t opB;
    cpuPkg::word_t aluB;
    cpuPkg::word_t aluOut;
    cpuPkg::word_t pcPlus1;
    cpuPkg::word_t branchPc;
    logic notEqual;
    logic lessThan;
    logic taken;

    // one operand mux, used for both ports
    function automatic cpuPkg::word_t pickOperand(input cpuPkg::bypassSel_t sel,
                                                  input cpuPkg::word_t regVal,
                                                  input cpuPkg::word_t memVal,
                                                  input cpuPkg::word_t wbVal);
        case (sel)
            cpuPkg::selMem: return memVal;
            cpuPkg::selWb:  return wbVal;
            default:        return regVal;
        endcase
    endfunction

    assign opA = pickOperand(selA, dx.opA, memResult, wbData);
    assign opB = pickOperand(selB, dx.opB, memResult, wbData);

    // addi, lw and sw take the sign-extended immediate
    assign aluB = dx.ctrl.immSel ? dx.imm : opB;

    always_comb begin
        case (dx.ctrl.aluOp)
            cpuPkg::aluAdd: aluOut = opA + aluB;
            cpuPkg::aluSub: aluOut = opA - aluB;
            cpuPkg::aluAnd: aluOut = opA & aluB;
            cpuPkg::aluOr:  aluOut = opA | aluB;
            cpuPkg::aluSll: aluOut = opA << dx.shamt;
            cpuPkg::aluSra: aluOut = $signed(opA) >>> dx.shamt;
            default:        aluOut = '0;
        endcase
    end

    // branch compare is rd (port A) against rs (port B), signed
    assign notEqual = opA != opB;
    assign lessThan = $signed(opA) < $signed(opB);

    assign pcPlus1  = dx.pc + 32'd1;
    assign branchPc = pcPlus1 + dx.imm;

    assign taken    = (dx.ctrl.bne && notEqual) || (dx.ctrl.blt && lessThan);
    assign redirect = taken || dx.ctrl.jump || dx.ctrl.jumpReg;

    // jr target is the bypassed rd value on port B
    always_comb begin
        if (dx.ctrl.jumpReg)
            redirectPc = opB;
        else if (dx.ctrl.jump)
            redirectPc = dx.target;
        else
            redirectPc = branchPc;
    end

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            xm <= '0;
        end else begin
            xm <= '{
                // jal writes its return address
                result:    dx.ctrl.link ? pcPlus1 : aluOut,
                storeData: opB,
                storeIdx:  dx.srcB,
                dest:      dx.dest,
                ctrl:      dx.ctrl
            };
        end
    end

    // both younger slots are squashed, so the next one can not redirect
    redirectSquashes: assert property (@(posedge clock) disable iff (!arstN)
        redirect |=> dx.ctrl == '0 && !redirect);

endmodule

/* cpuDecode.sv */
//##############################
// decode stage
// control decode, register reads with
// writeback bypass, decode/execute register
//##############################
`timescale 1ns/1ns
module cpuDecode (
    input  logic            clock,
    input  logic            arstN,
    input  cpuPkg::fdReg_t  fd,
    input  logic            stall,
    input  logic            redirect,
    output cpuPkg::regIdx_t readIdxA,
    output cpuPkg::regIdx_t readIdxB,
    input  cpuPkg::word_t   readDataA,
    input  cpuPkg::word_t   readDataB,
    input  cpuPkg::regIdx_t wbIdx,
    input  cpuPkg::word_t   wbData,
    input  logic            wbEn,
    output logic            decNeedsB,
    output cpuPkg::dxReg_t  dx
);

    cpuPkg::opcode_t opcode;
    cpuPkg::regIdx_t rd;
    cpuPkg::regIdx_t rs;
    cpuPkg::regIdx_t rt;
    cpuPkg::aluOp_t  aluField;
    cpuPkg::regIdx_t dest;
    cpuPkg::ctrl_t   ctrl;
    cpuPkg::word_t   valA;
    cpuPkg::word_t   valB;
    logic isRtype, isAddi, isLw, isSw, isBne, isBlt, isJ, isJal, isJr;
    logic aluKnown;

    // instruction fields
    assign opcode   = fd.instr[31:27];
    assign rd       = fd.instr[26:22];
    assign rs       = fd.instr[21:17];
    assign rt       = fd.instr[16:12];
    assign aluField = fd.instr[6:2];

    assign isRtype = opcode == cpuPkg::opRtype;
    assign isAddi  = opcode == cpuPkg::opAddi;
    assign isLw    = opcode == cpuPkg::opLw;
    assign isSw    = opcode == cpuPkg::opSw;
    assign isBne   = opcode == cpuPkg::opBne;
    assign isBlt   = opcode == cpuPkg::opBlt;
    assign isJ     = opcode == cpuPkg::opJ;
    assign isJal   = opcode == cpuPkg::opJal;
    assign isJr    = opcode == cpuPkg::opJr;

    // unsupported R-type functions behave as no-ops
    assign aluKnown = aluField inside {cpuPkg::aluAdd, cpuPkg::aluSub, cpuPkg::aluAnd,
                                       cpuPkg::aluOr, cpuPkg::aluSll, cpuPkg::aluSra};

    // jal links into r31
    assign dest = isJal ? cpuPkg::linkReg : rd;

    always_comb begin
        // never enable a write to r0
        ctrl.regWrite = ((isRtype && aluKnown) || isAddi || isLw || isJal) && dest != '0;
        ctrl.memWrite = isSw;
        ctrl.memRead  = isLw;
        ctrl.immSel   = isAddi || isLw || isSw;
        ctrl.bne      = isBne;
        ctrl.blt      = isBlt;
        ctrl.jump     = isJ || isJal;
        ctrl.jumpReg  = isJr;
        ctrl.link     = isJal;
        // address and addi math reuse the adder
        ctrl.aluOp    = isRtype ? aluField : cpuPkg::aluAdd;
    end

    // branches compare rd against rs
    // sw reads its store data and jr its target from rd on port B
    assign readIdxA = (isBne || isBlt) ? rd : rs;
    assign readIdxB = (isBne || isBlt) ? rs : ((isSw || isJr) ? rd : rt);

    // store data is only due in memory, where it gets its own bypass
    assign decNeedsB = isRtype || isBne || isBlt || isJr;

    // same-cycle writeback is not yet visible in the register file
    assign valA = (wbEn && wbIdx == readIdxA) ? wbData : readDataA;
    assign valB = (wbEn && wbIdx == readIdxB) ? wbData : readDataB;

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            dx <= '0;
        end else begin
            dx <= '{
                pc:     fd.pc,
                opA:    valA,
                opB:    valB,
                imm:    {{15{fd.instr[16]}}, fd.instr[16:0]},
                target: {5'b0, fd.instr[26:0]},
                srcA:   readIdxA,
                srcB:   readIdxB,
                dest:   dest,
                shamt:  fd.instr[11:7],
                // bubble on load-use stall or branch flush
                ctrl:   (stall || redirect) ? '0 : ctrl
            };
        end
    end

endmodule

/* cpuFetch.sv */
//##############################
// fetch stage
// program counter and fetch/decode register
//##############################
`timescale 1ns/1ns
module cpuFetch #(
    parameter cpuPkg::word_t resetPc = '0
) (
    input  logic           clock,
    input  logic           arstN,
    input  logic           stall,
    input  logic           redirect,
    input  cpuPkg::word_t  redirectPc,
    input  cpuPkg::word_t  instr,
    output cpuPkg::word_t  imemAddr,
    output cpuPkg::fdReg_t fd
);

    cpuPkg::word_t pc;
    cpuPkg::word_t pcNext;

    // instruction memory answers within the cycle
    assign imemAddr = pc;

    // redirect wins over stall, they never coincide anyway
    always_comb begin
        if (redirect)
            pcNext = redirectPc;
        else if (stall)
            pcNext = pc;
        else
            pcNext = pc + 32'd1;
    end

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN)
            pc <= resetPc;
        else
            pc <= pcNext;
    end

    // flushed slot becomes instruction 0, an add into r0
    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN)
            fd <= '0;
        else if (redirect)
            fd <= '0;
        else if (!stall)
            fd <= '{instr: instr, pc: pc};
    end

    // a load-use stall holds the address for exactly one cycle
    pcHeldOnStall: assert property (@(posedge clock) disable iff (!arstN)
        stall && !redirect |=> $stable(pc) && !stall);

endmodule

/* cpuPkg.sv */
//##############################
// shared types for the five-stage core
// opcode and ALU encodings, bypass selects
// and the pipeline register structs
//##############################
package cpuPkg;

    // data and address word
    typedef logic [31:0] word_t;
    // register file index
    typedef logic [4:0] regIdx_t;
    typedef logic [4:0] opcode_t;
    typedef logic [4:0] aluOp_t;
    // where an execute operand comes from
    typedef logic [1:0] bypassSel_t;

    // kept opcodes, anything else decodes as a no-op
    localparam opcode_t opRtype = 5'b00000;
    localparam opcode_t opJ     = 5'b00001;
    localparam opcode_t opBne   = 5'b00010;
    localparam opcode_t opJal   = 5'b00011;
    localparam opcode_t opJr    = 5'b00100;
    localparam opcode_t opAddi  = 5'b00101;
    localparam opcode_t opBlt   = 5'b00110;
    localparam opcode_t opSw    = 5'b00111;
    localparam opcode_t opLw    = 5'b01000;

    // R-type function field
    localparam aluOp_t aluAdd = 5'b00000;
    localparam aluOp_t aluSub = 5'b00001;
    localparam aluOp_t aluAnd = 5'b00010;
    localparam aluOp_t aluOr  = 5'b00011;
    localparam aluOp_t aluSll = 5'b00100;
    localparam aluOp_t aluSra = 5'b00101;

    localparam bypassSel_t selReg = 2'd0;
    localparam bypassSel_t selMem = 2'd1;
    localparam bypassSel_t selWb  = 2'd2;

    // jal return address register
    localparam regIdx_t linkReg = 5'd31;

    // all zero is a bubble
    typedef struct packed {
        logic   regWrite;
        logic   memWrite;
        logic   memRead;
        logic   immSel;
        logic   bne;
        logic   blt;
        logic   jump;
        logic   jumpReg;
        logic   link;
        aluOp_t aluOp;
    } ctrl_t;

    typedef struct packed {
        word_t instr;
        word_t pc;
    } fdReg_t;

    typedef struct packed {
        word_t      pc;
        word_t      opA;
        word_t      opB;
        word_t      imm;
        word_t      target;
        regIdx_t    srcA;
        regIdx_t    srcB;
        regIdx_t    dest;
        logic [4:0] shamt;
        ctrl_t      ctrl;
    } dxReg_t;

    typedef struct packed {
        word_t   result;
        word_t   storeData;
        regIdx_t storeIdx;
        regIdx_t dest;
        ctrl_t   ctrl;
    } xmReg_t;

    typedef struct packed {
        word_t   result;
        word_t   loadData;
        regIdx_t dest;
        logic    regWrite;
        logic    memRead;
    } mwReg_t;

endpackage
